// File: rtl/conv_cfg.svh
// Configuration of the convolution fetch unit
// Geometry, counts, PE command codes and APB register map
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Image and block geometry
`define CONV_BANK_W      14       // Words per row of each image bank
`define CONV_BLOCKS_ROW  13       // Blocks per row and per column

// Layer counts
`define CONV_FILTERS     32       // Also reset value of NFILT
`define CONV_TAPS        9
`define CONV_BEATS       11       // Beats per block

// SSFR instruction, max pooling plus ReLU
`define CONV_SSFR_OP     8'hC1
`define CONV_SSFR_ARG    8'h28

`define CONV_ADDR_CTRL   12'h000
`define CONV_ADDR_STATUS 12'h004
`define CONV_ADDR_NFILT  12'h008

`define CONV_IMG_AW      10
`define CONV_W_AW        15
`define CONV_RES_AW      14

`endif

// File: rtl/conv_pkg.sv
// Shared types of the convolution fetch unit
// PE beats, residue writes and APB transfers
`include "conv_cfg.svh"

package conv_pkg;

    typedef enum logic [1:0] {
        CMD_MAC  = 2'd0,
        TAP      = 2'd1,
        CMD_SSFR = 2'd2
    } beat_kind_e;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  mac_count;
        logic [15:0] reserved;
    } lane_cmd_t;

    // Four pixels on a tap beat, a command on MAC and SSFR beats
    typedef union packed {
        logic [3:0][7:0] pixels;     // Pixel 0 in the low byte
        lane_cmd_t       cmd;
    } lane_word_u;

    typedef struct packed {
        logic       valid;
        beat_kind_e kind;
        lane_word_u lanes;
        logic [7:0] param;           // Bias, weight or SSFR argument
    } pe_beat_t;

    typedef struct packed {
        logic                    en;
        logic [1:0]              bank;
        logic [`CONV_RES_AW-1:0] addr;
        logic [7:0]              data;
    } res_wr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

// File: rtl/conv_apb_regs.sv
// APB register block of the fetch unit
// Control, status and filter count, start pulse and sticky done flag
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_apb_regs (
    input  logic               clk,
    input  logic               reset,
    input  conv_pkg::apb_req_t apb_req,
    output conv_pkg::apb_rsp_t apb_rsp,
    input  logic               seq_busy,
    output logic               start,
    output logic [5:0]         n_filters
);

    logic access;
    logic wr_en;
    logic sel_ctrl;
    logic sel_status;
    logic sel_nfilt;
    logic nfilt_ok;
    logic busy_q;
    logic done;

    assign access     = apb_req.psel && apb_req.penable;
    assign wr_en      = access && apb_req.pwrite;
    assign sel_ctrl   = (apb_req.paddr == `CONV_ADDR_CTRL);
    assign sel_status = (apb_req.paddr == `CONV_ADDR_STATUS);
    assign sel_nfilt  = (apb_req.paddr == `CONV_ADDR_NFILT);
    assign nfilt_ok   = (apb_req.pwdata >= 32'd1) && (apb_req.pwdata <= 32'(`CONV_FILTERS));

    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= 1'b0;
            n_filters <= 6'(`CONV_FILTERS);
            busy_q    <= 1'b0;
            done      <= 1'b0;
        end else begin
            busy_q <= seq_busy;
            // One-cycle pulse, ignored while a layer runs
            start  <= wr_en && sel_ctrl && apb_req.pwdata[0] && !seq_busy && !start;
            if (wr_en && sel_nfilt && nfilt_ok)
                n_filters <= apb_req.pwdata[5:0];   // Out-of-range values dropped
            if (start)
                done <= 1'b0;
            else if (busy_q && !seq_busy)
                done <= 1'b1;                       // Last block of the layer done
        end
    end

    // No wait states, read data valid in the access cycle
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !(sel_ctrl || sel_status || sel_nfilt);
        apb_rsp.prdata  = '0;
        if (apb_req.psel && !apb_req.pwrite) begin
            if (sel_status)
                apb_rsp.prdata = {30'b0, done, seq_busy};
            else if (sel_nfilt)
                apb_rsp.prdata = {26'b0, n_filters};
        end
    end

    // Start only from idle, and the sequencer picks it up on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        start |-> !seq_busy ##1 seq_busy);

endmodule

// File: rtl/conv_block_seq.sv
// Block sequencer of the first convolution layer
// Walks filters and blocks row-major in 12-phase periods, drives image and weight reads
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_block_seq (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [5:0]              n_filters,
    output logic [`CONV_IMG_AW-1:0] img_addr,
    output logic [`CONV_W_AW-1:0]   w_addr,
    output logic [3:0]              phase,
    output logic                    busy
);

    localparam int         IMG_AW     = `CONV_IMG_AW;
    localparam int         W_AW       = `CONV_W_AW;
    localparam int         W_PER_FILT = `CONV_TAPS + 1;     // Bias then the taps
    localparam logic [3:0] LAST_PHASE = 4'(`CONV_BEATS);    // Phase 0 plus one per beat
    localparam logic [3:0] LAST_BLK   = 4'(`CONV_BLOCKS_ROW - 1);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e            state;
    logic [3:0]        blk_col;
    logic [3:0]        blk_row;
    logic [5:0]        filter;
    logic [5:0]        n_filt_q;
    logic              last_blk;
    logic              last_filt;
    logic [IMG_AW-1:0] img_base;

    assign busy      = (state == RUN);
    assign last_blk  = (blk_col == LAST_BLK) && (blk_row == LAST_BLK);
    assign last_filt = (filter == n_filt_q - 6'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            phase    <= '0;
            blk_col  <= '0;
            blk_row  <= '0;
            filter   <= '0;
            n_filt_q <= 6'd1;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        phase    <= '0;
                        blk_col  <= '0;
                        blk_row  <= '0;
                        filter   <= '0;
                        n_filt_q <= n_filters;   // Held for the whole layer
                    end
                end
                RUN: begin
                    if (phase != LAST_PHASE) begin
                        phase <= phase + 4'd1;
                    end else begin
                        phase <= '0;
                        if (last_blk) begin
                            blk_col <= '0;
                            blk_row <= '0;
                            filter  <= filter + 6'd1;
                            if (last_filt)
                                state <= IDLE;
                        end else if (blk_col == LAST_BLK) begin
                            blk_col <= '0;
                            blk_row <= blk_row + 4'd1;
                        end else begin
                            blk_col <= blk_col + 4'd1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Phases 0..3 read base, base+1, base+row, base+row+1 from all four banks
    always_comb begin
        img_base = IMG_AW'(blk_row) * IMG_AW'(`CONV_BANK_W) + IMG_AW'(blk_col);
        img_addr = img_base + (phase[1] ? IMG_AW'(`CONV_BANK_W) : '0) + IMG_AW'(phase[0]);
    end

    assign w_addr = W_AW'(filter) * W_AW'(W_PER_FILT) + W_AW'(phase);   // Bias at offset 0

    // Fixed block period, and the counter parks at zero when idle
    assert property (@(posedge clk) disable iff (reset)
        (phase <= LAST_PHASE) && (busy || phase == 4'd0));

endmodule

// File: rtl/conv_window_buf.sv
// Window buffer and beat builder
// Holds the 4x4 pixel window of a block and emits MAC, tap and SSFR beats to the PE
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_window_buf (
    input  logic               clk,
    input  logic               reset,
    input  logic [3:0]         phase,
    input  logic               busy,
    input  logic [31:0]        img_q,
    input  logic [7:0]         w_q,
    output conv_pkg::pe_beat_t beat
);

    localparam logic [3:0] FIRST_TAP  = 4'd2;
    localparam logic [3:0] SSFR_PHASE = 4'(`CONV_BEATS);

    // Window slots of each 3x3 tap, lane 0 first
    localparam logic [3:0] TAP_SLOT [0:`CONV_TAPS-1][0:3] = '{
        '{4'd0,  4'd1,  4'd2,  4'd3},
        '{4'd1,  4'd4,  4'd3,  4'd6},
        '{4'd4,  4'd5,  4'd6,  4'd7},
        '{4'd2,  4'd3,  4'd8,  4'd9},
        '{4'd3,  4'd6,  4'd9,  4'd12},
        '{4'd6,  4'd7,  4'd12, 4'd13},
        '{4'd8,  4'd9,  4'd10, 4'd11},
        '{4'd9,  4'd12, 4'd11, 4'd14},
        '{4'd12, 4'd13, 4'd14, 4'd15}
    };

    logic [7:0]           win [0:15];
    logic                 fill_en;
    logic [1:0]           fill_row;
    logic                 emit_en;
    logic [3:0]           tap_idx;
    conv_pkg::beat_kind_e kind_next;
    conv_pkg::lane_word_u lanes_next;
    logic [7:0]           param_next;
    logic                 valid_q;
    conv_pkg::beat_kind_e kind_q;
    conv_pkg::lane_word_u lanes_q;
    logic [7:0]           param_q;

    // Read issued at phase k lands at phase k+1
    assign fill_en  = busy && (phase >= 4'd1) && (phase <= 4'd4);
    assign fill_row = 2'(phase - 4'd1);
    assign emit_en  = busy && (phase != 4'd0);

    always_ff @(posedge clk) begin
        if (fill_en) begin
            for (int b = 0; b < 4; b++) begin
                win[{fill_row, 2'(b)}] <= img_q[8*b +: 8];   // Bank b
            end
        end
    end

    always_comb begin
        tap_idx    = (phase >= FIRST_TAP && phase < SSFR_PHASE) ? phase - FIRST_TAP : 4'd0;
        kind_next  = conv_pkg::TAP;
        lanes_next = '0;
        param_next = w_q;                          // Bias at phase 1, weight t at t+2
        if (phase == 4'd1) begin
            kind_next                = conv_pkg::CMD_MAC;
            lanes_next.cmd.mac_count = 8'(`CONV_TAPS);
        end else if (phase == SSFR_PHASE) begin
            kind_next             = conv_pkg::CMD_SSFR;
            lanes_next.cmd.opcode = `CONV_SSFR_OP;
            param_next            = `CONV_SSFR_ARG;
        end else begin
            for (int i = 0; i < 4; i++) begin
                lanes_next.pixels[i] = win[TAP_SLOT[tap_idx][i]];
            end
        end
    end

    // Beat built in a phase reaches the PE one cycle later
    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= emit_en;
    end

    always_ff @(posedge clk) begin
        if (emit_en) begin
            kind_q  <= kind_next;
            lanes_q <= lanes_next;
            param_q <= param_next;
        end
    end

    assign beat = '{valid: valid_q, kind: kind_q, lanes: lanes_q, param: param_q};

endmodule

// File: rtl/conv_res_writeback.sv
// Residue write-back of PE results
// Rotates results over four banks, shared address steps after every bank 3 write
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_res_writeback (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              pe_result_valid,
    input  logic [7:0]        pe_result,
    output conv_pkg::res_wr_t res_wr
);

    logic [1:0]              bank_q;
    logic [`CONV_RES_AW-1:0] addr_q;
    logic                    wr_en_q;
    logic [1:0]              wr_bank_q;
    logic [`CONV_RES_AW-1:0] wr_addr_q;
    logic [7:0]              wr_data_q;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            bank_q <= '0;                   // New layer starts at bank 0, word 0
            addr_q <= '0;
        end else if (pe_result_valid) begin
            bank_q <= bank_q + 2'd1;
            if (bank_q == 2'd3)
                addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            wr_en_q <= 1'b0;
        else
            wr_en_q <= pe_result_valid;
    end

    always_ff @(posedge clk) begin
        if (pe_result_valid) begin
            wr_bank_q <= bank_q;
            wr_addr_q <= addr_q;
            wr_data_q <= pe_result;
        end
    end

    assign res_wr = '{en: wr_en_q, bank: wr_bank_q, addr: wr_addr_q, data: wr_data_q};

    // All results of one layer fit in the residue banks
    assert property (@(posedge clk) disable iff (reset)
        (pe_result_valid && !start && bank_q == 2'd3) |-> (addr_q != '1));

endmodule

// File: rtl/conv_fetch_top.sv
// Feature-map fetch unit of the first convolution layer
// APB registers, block sequencer, window buffer and residue write-back
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  conv_pkg::apb_req_t      apb_req,
    output conv_pkg::apb_rsp_t      apb_rsp,
    output logic [`CONV_IMG_AW-1:0] img_addr,
    input  logic [31:0]             img_q,      // Banks 0..3, bank 0 low
    output logic [`CONV_W_AW-1:0]   w_addr,
    input  logic [7:0]              w_q,
    output conv_pkg::pe_beat_t      beat,
    input  logic                    pe_result_valid,
    input  logic [7:0]              pe_result,
    output conv_pkg::res_wr_t       res_wr
);

    logic       start;
    logic [5:0] n_filters;
    logic [3:0] phase;
    logic       busy;

    conv_apb_regs conv_apb_regs_i (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .seq_busy  (busy),
        .start     (start),
        .n_filters (n_filters)
    );

    conv_block_seq conv_block_seq_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .n_filters (n_filters),
        .img_addr  (img_addr),
        .w_addr    (w_addr),
        .phase     (phase),
        .busy      (busy)
    );

    conv_window_buf conv_window_buf_i (
        .clk   (clk),
        .reset (reset),
        .phase (phase),
        .busy  (busy),
        .img_q (img_q),
        .w_q   (w_q),
        .beat  (beat)
    );

    conv_res_writeback conv_res_writeback_i (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .pe_result_valid (pe_result_valid),
        .pe_result       (pe_result),
        .res_wr          (res_wr)
    );

endmodule

// File: sim/conv_fetch_tb.sv
// Testbench of the convolution fetch unit
// APB host, image and weight memory models, beat stream and residue write checks
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_fetch_tb;

    localparam int BLOCKS     = `CONV_BLOCKS_ROW * `CONV_BLOCKS_ROW;
    localparam int W_PER_FILT = `CONV_TAPS + 1;

    // Window slots per tap, lane 0 first
    localparam int TAP_SLOT [0:8][0:3] = '{
        '{0, 1, 2, 3},   '{1, 4, 3, 6},   '{4, 5, 6, 7},
        '{2, 3, 8, 9},   '{3, 6, 9, 12},  '{6, 7, 12, 13},
        '{8, 9, 10, 11}, '{9, 12, 11, 14}, '{12, 13, 14, 15}
    };

    typedef struct packed {
        logic [31:0] wr_nfilt;    // Value written to NFILT
        logic [5:0]  exp_nfilt;   // NFILT read back, also filters run
        logic [7:0]  n_results;   // PE results injected during the layer
        logic        poke_busy;   // Write start again while busy
    } case_t;

    // Third row writes an out-of-range NFILT, so the layer repeats with 2 filters
    localparam case_t CASES [0:2] = '{
        '{wr_nfilt: 32'd1, exp_nfilt: 6'd1, n_results: 8'd6, poke_busy: 1'b0},
        '{wr_nfilt: 32'd2, exp_nfilt: 6'd2, n_results: 8'd9, poke_busy: 1'b1},
        '{wr_nfilt: 32'd0, exp_nfilt: 6'd2, n_results: 8'd5, poke_busy: 1'b0}
    };

    logic                    clk;
    logic                    reset;
    conv_pkg::apb_req_t      apb_req;
    conv_pkg::apb_rsp_t      apb_rsp;
    logic [`CONV_IMG_AW-1:0] img_addr;
    logic [31:0]             img_q;
    logic [`CONV_W_AW-1:0]   w_addr;
    logic [7:0]              w_q;
    conv_pkg::pe_beat_t      beat;
    logic                    pe_result_valid;
    logic [7:0]              pe_result;
    conv_pkg::res_wr_t       res_wr;

    logic [31:0] img_mem [0:(1 << `CONV_IMG_AW) - 1];
    logic [7:0]  w_mem [0:(1 << `CONV_W_AW) - 1];
    logic [7:0]  res_exp [$];
    int          beat_cnt;
    int          res_seen;
    int          checks;
    int          errors;
    int unsigned seed_val;

    conv_fetch_top conv_fetch_top_i (
        .clk             (clk),
        .reset           (reset),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .img_addr        (img_addr),
        .img_q           (img_q),
        .w_addr          (w_addr),
        .w_q             (w_q),
        .beat            (beat),
        .pe_result_valid (pe_result_valid),
        .pe_result       (pe_result),
        .res_wr          (res_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Synchronous memories, one cycle of read latency
    always @(posedge clk) begin
        img_q <= img_mem[img_addr];
        w_q   <= w_mem[w_addr];
    end

    function automatic logic [7:0] pixel_at(int base, int slot);
        int rd;
        rd = slot / 4;                  // Read k fills slots 4k..4k+3
        return img_mem[base + (rd / 2) * `CONV_BANK_W + rd % 2][8 * (slot % 4) +: 8];
    endfunction

    function automatic bit beat_matches(int idx, conv_pkg::pe_beat_t b);
        int j;
        int blk;
        int f;
        int base;
        bit ok;
        j    = idx % `CONV_BEATS;
        blk  = (idx / `CONV_BEATS) % BLOCKS;
        f    = idx / (`CONV_BEATS * BLOCKS);
        base = (blk / `CONV_BLOCKS_ROW) * `CONV_BANK_W + blk % `CONV_BLOCKS_ROW;
        if (j == 0) begin
            ok = (b.kind == conv_pkg::CMD_MAC) && (b.lanes.cmd.mac_count == 8'(`CONV_TAPS))
                 && (b.param == w_mem[f * W_PER_FILT]);
        end else if (j == `CONV_BEATS - 1) begin
            ok = (b.kind == conv_pkg::CMD_SSFR) && (b.lanes.cmd.opcode == `CONV_SSFR_OP)
                 && (b.param == `CONV_SSFR_ARG);
        end else begin
            ok = (b.kind == conv_pkg::TAP) && (b.param == w_mem[f * W_PER_FILT + j]);
            for (int i = 0; i < 4; i++) begin
                if (b.lanes.pixels[i] != pixel_at(base, TAP_SLOT[j - 1][i]))
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Monitor on the falling edge, where DUT outputs are settled
    always @(negedge clk) begin
        if (!reset && beat.valid) begin
            checks++;
            assert (beat_matches(beat_cnt, beat)) else begin
                errors++;
                $display("ERROR %0t: beat %0d wrong, kind %0d lanes %h param %h",
                         $time, beat_cnt, beat.kind, beat.lanes, beat.param);
            end
            beat_cnt++;
        end
        if (!reset && res_wr.en) begin
            checks++;
            assert (res_exp.size() != 0 && res_wr.bank == 2'(res_seen % 4)
                    && res_wr.addr == 14'(res_seen / 4) && res_wr.data == res_exp[0]) else begin
                errors++;
                $display("ERROR %0t: residue write %0d wrong, bank %0d addr %0d data %h",
                         $time, res_seen, res_wr.bank, res_wr.addr, res_wr.data);
            end
            if (res_exp.size() != 0)
                void'(res_exp.pop_front());
            res_seen++;
        end
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Setup and access cycle, no wait states
    task automatic apb_xfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_equal("pready", apb_rsp.pready, 1);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic wait_beats(input int total);
        int cycles;
        cycles = 0;
        while (beat_cnt < total && cycles < 2 * total + 100) begin
            @(posedge clk);
            cycles++;
        end
        if (beat_cnt < total) begin
            $display("Timed out after %0d of %0d PE beats", beat_cnt, total);
            $display("Test failed");
            $finish;
        end
    endtask

    // Poll STATUS until the sticky done bit shows up
    task automatic wait_done(output logic [31:0] status);
        int   polls;
        logic err;
        polls = 0;
        apb_xfer(1'b0, `CONV_ADDR_STATUS, 32'd0, status, err);
        while (!status[1] && polls < 50) begin
            apb_xfer(1'b0, `CONV_ADDR_STATUS, 32'd0, status, err);
            polls++;
        end
        if (!status[1]) begin
            $display("Timed out waiting for the done flag");
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic inject_results(input int n);
        logic [7:0] data;
        for (int i = 0; i < n; i++) begin
            data = 8'($urandom);
            @(posedge clk);
            pe_result       <= data;
            pe_result_valid <= 1'b1;
            res_exp.push_back(data);
            @(posedge clk);
            pe_result_valid <= 1'b0;
        end
    endtask

    task automatic run_case(input case_t tc);
        logic [31:0] rd;
        logic        err;
        int          total;
        total = tc.exp_nfilt * BLOCKS * `CONV_BEATS;
        apb_xfer(1'b1, `CONV_ADDR_NFILT, tc.wr_nfilt, rd, err);
        apb_xfer(1'b0, `CONV_ADDR_NFILT, 32'd0, rd, err);
        check_equal("NFILT readback", rd, tc.exp_nfilt);
        check_equal("NFILT pslverr", err, 0);
        beat_cnt = 0;
        res_seen = 0;
        apb_xfer(1'b1, `CONV_ADDR_CTRL, 32'd1, rd, err);
        wait_beats(1);
        apb_xfer(1'b0, `CONV_ADDR_STATUS, 32'd0, rd, err);
        check_equal("STATUS while running", rd, 32'd1);   // Busy, done cleared
        inject_results(tc.n_results);
        if (tc.poke_busy) begin
            apb_xfer(1'b1, `CONV_ADDR_CTRL, 32'd1, rd, err);
            apb_xfer(1'b0, `CONV_ADDR_STATUS, 32'd0, rd, err);
            check_equal("STATUS after start while busy", rd, 32'd1);
            inject_results(tc.n_results);                  // Bank and address carry on
        end
        wait_beats(total);
        wait_done(rd);
        check_equal("STATUS after layer", rd, 32'd2);
        repeat (2 * `CONV_BEATS) @(posedge clk);           // Quiet window after done
        check_equal("beat count", beat_cnt, total);
        check_equal("pending residue writes", res_exp.size(), 0);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        reset           = 1'b1;
        apb_req         = '0;
        img_q           = '0;
        w_q             = '0;
        pe_result_valid = 1'b0;
        pe_result       = '0;
        beat_cnt        = 0;
        res_seen        = 0;
        checks          = 0;
        errors          = 0;
        seed_val        = $urandom(32'hec5061f6);
        foreach (img_mem[a])
            img_mem[a] = $urandom;
        foreach (w_mem[a])
            w_mem[a] = 8'($urandom);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        apb_xfer(1'b0, `CONV_ADDR_STATUS, 32'd0, rd, err);
        check_equal("STATUS after reset", rd, 32'd0);
        check_equal("STATUS pslverr", err, 0);
        apb_xfer(1'b1, 12'h00C, 32'd5, rd, err);
        check_equal("unmapped write pslverr", err, 1);
        apb_xfer(1'b0, 12'h00C, 32'd0, rd, err);
        check_equal("unmapped read data", rd, 32'd0);
        check_equal("unmapped read pslverr", err, 1);
        apb_xfer(1'b0, `CONV_ADDR_NFILT, 32'd0, rd, err);
        check_equal("NFILT reset value", rd, 32'(`CONV_FILTERS));

        for (int c = 0; c < 3; c++)
            run_case(CASES[c]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_apb_regs.sv
rtl/conv_block_seq.sv
rtl/conv_window_buf.sv
rtl/conv_res_writeback.sv
rtl/conv_fetch_top.sv
sim/conv_fetch_tb.sv
